// ==== rtl/snn_conv_params.svh ====
////////////////////////////////////////
// spiking conv row sizing
// quantization, pe size, time steps and
// image width for the whole datapath
////////////////////////////////////////

`ifndef SNN_CONV_PARAMS_SVH
`define SNN_CONV_PARAMS_SVH

// weight width and kernel size
`define QUAN_BITS     8
`define ERS_PE_SIZE   3

// spikes per pixel and pixels per row
`define TIME_STEPS    4
`define IMG_WIDTH     8

`define IN_DATA_BITS  32
`define COL_BITS      3

`endif

// ==== rtl/snn_conv_pkg.sv ====
////////////////////////////////////////
// spiking conv row types
// opcodes, controller states and the
// sized datapath signal types
////////////////////////////////////////

`include "snn_conv_params.svh"

package snn_conv_pkg;

    typedef enum logic {
        OP_WEIGHT = 1'b0,
        OP_SPIKE  = 1'b1
    } in_op_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LOAD  = 2'd1,
        ST_CALC  = 2'd2,
        ST_FLUSH = 2'd3
    } ctrl_state_e;

    typedef logic signed [`QUAN_BITS-1:0] weight_t;
    // sum of three weights needs two extra bits
    typedef logic signed [`QUAN_BITS+1:0] psum_t;
    typedef psum_t [`TIME_STEPS-1:0]      psum_vec_t;
    typedef logic signed [13:0]           vmem_t;
    typedef logic [`TIME_STEPS-1:0]       spike_vec_t;

endpackage

// ==== rtl/eyeriss_pe.sv ====
////////////////////////////////////////
// row-stationary pe
// holds one kernel row and one padded
// spike row, one partial sum per step
////////////////////////////////////////

`timescale 1ns/1ps

`include "snn_conv_params.svh"

module eyeriss_pe (
    input  logic                                   s_clk,
    input  logic                                   s_rst,
    input  logic                                   i_weight_valid,
    input  logic [`QUAN_BITS*`ERS_PE_SIZE-1:0]     i_weights,
    input  logic                                   i_spikes_valid,
    input  logic [`IMG_WIDTH*`TIME_STEPS-1:0]      i_spikes,
    input  logic                                   i_cal_start,
    output snn_conv_pkg::psum_vec_t                o_psum
);

    import snn_conv_pkg::*;

    weight_t                                  r_weight [`ERS_PE_SIZE];
    // slot 0 is the left pad, pixel p sits in slot p+1
    logic [`TIME_STEPS*(`IMG_WIDTH+1)-1:0]    r_spikes;
    psum_vec_t                                r_psum;
    psum_vec_t                                w_psum;

    // window is the lowest three slots, weight 0 on the left
    always_comb begin
        for (int t = 0; t < `TIME_STEPS; t++) begin
            w_psum[t] = '0;
            for (int k = 0; k < `ERS_PE_SIZE; k++) begin
                if (r_spikes[t + `TIME_STEPS*k]) begin
                    w_psum[t] = w_psum[t] + psum_t'(r_weight[k]);
                end
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            for (int k = 0; k < `ERS_PE_SIZE; k++) begin
                r_weight[k] <= '0;
            end
        end else if (i_weight_valid) begin
            for (int k = 0; k < `ERS_PE_SIZE; k++) begin
                r_weight[k] <= i_weights[k*`QUAN_BITS +: `QUAN_BITS];
            end
        end
    end

    // shift down one pixel per step, zeros in from the top
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_spikes <= '0;
        end else if (i_cal_start) begin
            r_spikes <= r_spikes >> `TIME_STEPS;
        end else if (i_spikes_valid) begin
            r_spikes <= {i_spikes, {`TIME_STEPS{1'b0}}};
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_psum <= '0;
        end else if (i_cal_start) begin
            r_psum <= w_psum;
        end
    end

    assign o_psum = r_psum;

    // controller keeps loads out of the compute phase
    a_no_load_on_step: assert property (
        @(posedge s_clk) disable iff (s_rst)
        i_cal_start |-> !(i_weight_valid || i_spikes_valid)
    );

endmodule

// ==== rtl/if_neuron.sv ====
////////////////////////////////////////
// integrate-and-fire neuron
// sums three pe rows per step, fires on
// threshold, holds the output register
////////////////////////////////////////

`timescale 1ns/1ps

`include "snn_conv_params.svh"

module if_neuron (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  snn_conv_pkg::psum_vec_t      i_psum0,
    input  snn_conv_pkg::psum_vec_t      i_psum1,
    input  snn_conv_pkg::psum_vec_t      i_psum2,
    input  snn_conv_pkg::vmem_t          i_threshold,
    input  logic                         i_adv,
    input  logic [`COL_BITS-1:0]         i_col,
    input  logic                         i_pop,
    output logic                         o_valid,
    output snn_conv_pkg::spike_vec_t     o_spikes,
    output snn_conv_pkg::vmem_t          o_vmem,
    output logic [`COL_BITS-1:0]         o_col,
    output logic                         o_last
);

    import snn_conv_pkg::*;

    vmem_t                 w_vmem;
    spike_vec_t            w_spikes;
    logic                  r_valid;
    spike_vec_t            r_spikes;
    vmem_t                 r_vmem;
    logic [`COL_BITS-1:0]  r_col;
    logic                  r_last;

    // membrane starts at zero for every column
    always_comb begin
        w_vmem   = '0;
        w_spikes = '0;
        for (int t = 0; t < `TIME_STEPS; t++) begin
            w_vmem = w_vmem + vmem_t'(i_psum0[t]) + vmem_t'(i_psum1[t])
                   + vmem_t'(i_psum2[t]);
            if (w_vmem >= i_threshold) begin
                w_spikes[t] = 1'b1;
                // subtract reset
                w_vmem = w_vmem - i_threshold;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_valid <= 1'b0;
        end else if (i_adv) begin
            r_valid <= 1'b1;
        end else if (i_pop) begin
            r_valid <= 1'b0;
        end
    end

    always_ff @(posedge s_clk) begin
        if (i_adv) begin
            r_spikes <= w_spikes;
            r_vmem   <= w_vmem;
            r_col    <= i_col;
            r_last   <= (i_col == `COL_BITS'(`IMG_WIDTH - 1));
        end
    end

    assign o_valid  = r_valid;
    assign o_spikes = r_spikes;
    assign o_vmem   = r_vmem;
    assign o_col    = r_col;
    assign o_last   = r_last;

    // stalled result must not move
    a_out_stable: assert property (
        @(posedge s_clk) disable iff (s_rst)
        r_valid && !i_pop |=> r_valid && $stable(r_spikes) && $stable(r_vmem)
                              && $stable(r_col) && $stable(r_last)
    );

endmodule

// ==== rtl/conv_row_ctrl.sv ====
////////////////////////////////////////
// conv row controller
// routes input beats to the pes, paces
// column steps and the two-stage pipe
////////////////////////////////////////

`timescale 1ns/1ps

`include "snn_conv_params.svh"

module conv_row_ctrl (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_in_valid,
    input  snn_conv_pkg::in_op_e         i_in_op,
    input  logic                         i_out_valid,
    input  logic                         i_out_ready,
    output logic                         o_in_ready,
    output logic [`ERS_PE_SIZE-1:0]      o_wt_load,
    output logic [`ERS_PE_SIZE-1:0]      o_sp_load,
    output logic                         o_step,
    output logic                         o_adv,
    output logic [`COL_BITS-1:0]         o_col,
    output logic                         o_pop
);

    import snn_conv_pkg::*;

    ctrl_state_e           r_state;
    ctrl_state_e           w_next_state;
    logic [1:0]            r_wt_cnt;
    logic [1:0]            r_sp_cnt;
    logic [`COL_BITS-1:0]  r_step_col;
    logic [`COL_BITS-1:0]  r_pe_col;
    logic                  r_pe_full;
    logic                  w_wt_fire;
    logic                  w_sp_fire;
    logic                  w_wt_wrap;
    logic                  w_sp_wrap;
    logic                  w_last_step;

    assign o_in_ready = (r_state == ST_IDLE) || (r_state == ST_LOAD);
    assign w_wt_fire  = i_in_valid && o_in_ready && (i_in_op == OP_WEIGHT);
    assign w_sp_fire  = i_in_valid && o_in_ready && (i_in_op == OP_SPIKE);
    assign w_wt_wrap  = (r_wt_cnt == 2'(`ERS_PE_SIZE - 1));
    assign w_sp_wrap  = (r_sp_cnt == 2'(`ERS_PE_SIZE - 1));

    // one-hot pulse to the pe addressed by the beat count
    assign o_wt_load = w_wt_fire ? ({{(`ERS_PE_SIZE-1){1'b0}}, 1'b1} << r_wt_cnt) : '0;
    assign o_sp_load = w_sp_fire ? ({{(`ERS_PE_SIZE-1){1'b0}}, 1'b1} << r_sp_cnt) : '0;

    // stage 2 free or draining this cycle
    assign o_pop       = i_out_valid && i_out_ready;
    assign o_adv       = r_pe_full && (!i_out_valid || i_out_ready);
    assign o_step      = (r_state == ST_CALC) && (!r_pe_full || o_adv);
    assign w_last_step = o_step && (r_step_col == `COL_BITS'(`IMG_WIDTH - 1));
    assign o_col       = r_pe_col;

    always_comb begin
        w_next_state = r_state;
        case (r_state)
            ST_IDLE, ST_LOAD: begin
                if (w_sp_fire && w_sp_wrap) begin
                    w_next_state = ST_CALC;
                end else if (w_wt_fire && w_wt_wrap && r_sp_cnt == 2'd0) begin
                    w_next_state = ST_IDLE;
                end else if (w_wt_fire || w_sp_fire) begin
                    w_next_state = ST_LOAD;
                end
            end
            ST_CALC: begin
                if (w_last_step) begin
                    w_next_state = ST_FLUSH;
                end
            end
            ST_FLUSH: begin
                // last column leaves stage 1
                if (o_adv) begin
                    w_next_state = ST_IDLE;
                end
            end
            default: w_next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_state  <= ST_IDLE;
            r_wt_cnt <= '0;
            r_sp_cnt <= '0;
        end else begin
            r_state <= w_next_state;
            if (w_wt_fire) begin
                r_wt_cnt <= w_wt_wrap ? 2'd0 : r_wt_cnt + 2'd1;
            end
            if (w_sp_fire) begin
                r_sp_cnt <= w_sp_wrap ? 2'd0 : r_sp_cnt + 2'd1;
            end
        end
    end

    // column counter wraps to 0 after the last step
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            r_step_col <= '0;
            r_pe_col   <= '0;
            r_pe_full  <= 1'b0;
        end else begin
            if (o_step) begin
                r_step_col <= r_step_col + 1'b1;
                r_pe_col   <= r_step_col;
                r_pe_full  <= 1'b1;
            end else if (o_adv) begin
                r_pe_full  <= 1'b0;
            end
        end
    end

    // input stays closed while stage 1 holds a column
    a_ready_low_in_row: assert property (
        @(posedge s_clk) disable iff (s_rst)
        r_pe_full |-> !o_in_ready
    );

endmodule

// ==== rtl/spike_conv_top.sv ====
////////////////////////////////////////
// spiking conv row top
// controller, three row pes and the
// integrate-and-fire output stage
////////////////////////////////////////

`timescale 1ns/1ps

`include "snn_conv_params.svh"

module spike_conv_top (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_in_valid,
    output logic                         o_in_ready,
    input  snn_conv_pkg::in_op_e         i_in_op,
    input  logic [`IN_DATA_BITS-1:0]     i_in_data,
    input  snn_conv_pkg::vmem_t          i_threshold,
    output logic                         o_out_valid,
    input  logic                         i_out_ready,
    output snn_conv_pkg::spike_vec_t     o_out_spikes,
    output snn_conv_pkg::vmem_t          o_out_vmem,
    output logic [`COL_BITS-1:0]         o_out_col,
    output logic                         o_out_last
);

    import snn_conv_pkg::*;

    logic [`ERS_PE_SIZE-1:0]  w_wt_load;
    logic [`ERS_PE_SIZE-1:0]  w_sp_load;
    logic                     w_step;
    logic                     w_adv;
    logic                     w_pop;
    logic [`COL_BITS-1:0]     w_col;
    psum_vec_t                w_psum [`ERS_PE_SIZE];

    conv_row_ctrl conv_row_ctrl_inst (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_in_valid  (i_in_valid),
        .i_in_op     (i_in_op),
        .i_out_valid (o_out_valid),
        .i_out_ready (i_out_ready),
        .o_in_ready  (o_in_ready),
        .o_wt_load   (w_wt_load),
        .o_sp_load   (w_sp_load),
        .o_step      (w_step),
        .o_adv       (w_adv),
        .o_col       (w_col),
        .o_pop       (w_pop)
    );

    // pe k takes kernel row k and spike row k
    for (genvar g = 0; g < `ERS_PE_SIZE; g++) begin : g_pe
        eyeriss_pe eyeriss_pe_inst (
            .s_clk          (s_clk),
            .s_rst          (s_rst),
            .i_weight_valid (w_wt_load[g]),
            .i_weights      (i_in_data[`QUAN_BITS*`ERS_PE_SIZE-1:0]),
            .i_spikes_valid (w_sp_load[g]),
            .i_spikes       (i_in_data),
            .i_cal_start    (w_step),
            .o_psum         (w_psum[g])
        );
    end

    if_neuron if_neuron_inst (
        .s_clk       (s_clk),
        .s_rst       (s_rst),
        .i_psum0     (w_psum[0]),
        .i_psum1     (w_psum[1]),
        .i_psum2     (w_psum[2]),
        .i_threshold (i_threshold),
        .i_adv       (w_adv),
        .i_col       (w_col),
        .i_pop       (w_pop),
        .o_valid     (o_out_valid),
        .o_spikes    (o_out_spikes),
        .o_vmem      (o_out_vmem),
        .o_col       (o_out_col),
        .o_last      (o_out_last)
    );

endmodule

// ==== verif/spike_conv_tb.sv ====
////////////////////////////////////////
// spiking conv row testbench
// file driven input stream, random
// output back-pressure, column checks
////////////////////////////////////////

`timescale 1ns/1ps

`include "snn_conv_params.svh"

module spike_conv_tb;

    import snn_conv_pkg::*;

    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 4000;

    logic                      s_clk = 1'b0;
    logic                      s_rst;
    logic                      i_in_valid;
    logic                      o_in_ready;
    in_op_e                    i_in_op;
    logic [`IN_DATA_BITS-1:0]  i_in_data;
    vmem_t                     i_threshold;
    logic                      o_out_valid;
    logic                      i_out_ready = 1'b0;
    spike_vec_t                o_out_spikes;
    vmem_t                     o_out_vmem;
    logic [`COL_BITS-1:0]      o_out_col;
    logic                      o_out_last;

    in_op_e                    beat_op_q [$];
    logic [31:0]               beat_data_q [$];
    spike_vec_t                exp_spikes_q [$];
    vmem_t                     exp_vmem_q [$];
    logic [`COL_BITS-1:0]      exp_col_q [$];
    vmem_t                     threshold_cfg = '0;
    logic [31:0]               lfsr = 32'h344c_07e8;
    int                        mismatch_count = 0;
    int                        fail_count = 0;
    int                        rx_count = 0;
    int                        exp_total;
    int                        stall_cycles = 0;
    int                        spike_beats = 0;
    int                        beat_idx;
    int                        drain_cnt;
    logic                      timed_out = 1'b0;
    logic                      held_valid = 1'b0;
    spike_vec_t                held_spikes;
    vmem_t                     held_vmem;
    logic [`COL_BITS-1:0]      held_col;
    logic                      held_last;

    spike_conv_top spike_conv_top_inst (
        .s_clk        (s_clk),
        .s_rst        (s_rst),
        .i_in_valid   (i_in_valid),
        .o_in_ready   (o_in_ready),
        .i_in_op      (i_in_op),
        .i_in_data    (i_in_data),
        .i_threshold  (i_threshold),
        .o_out_valid  (o_out_valid),
        .i_out_ready  (i_out_ready),
        .o_out_spikes (o_out_spikes),
        .o_out_vmem   (o_out_vmem),
        .o_out_col    (o_out_col),
        .o_out_last   (o_out_last)
    );

    always #5 s_clk = ~s_clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic read_stimulus();
        int          fd;
        int          rc;
        int          ch;
        logic [7:0]  tag;
        logic [31:0] val;
        logic [31:0] vm;
        int          col;
        fd = $fopen("verif/spike_conv_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            fail_count++;
            return;
        end
        while ($fscanf(fd, " %c", tag) == 1) begin
            rc = 1;
            case (tag)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "T": begin
                    rc = $fscanf(fd, "%h", val);
                    threshold_cfg = val[13:0];
                end
                "W", "S": begin
                    rc = $fscanf(fd, "%h", val);
                    beat_op_q.push_back(tag == "W" ? OP_WEIGHT : OP_SPIKE);
                    beat_data_q.push_back(val);
                end
                "E": begin
                    rc = ($fscanf(fd, "%h %h %d", val, vm, col) == 3) ? 1 : 0;
                    exp_spikes_q.push_back(val[`TIME_STEPS-1:0]);
                    exp_vmem_q.push_back(vm[13:0]);
                    exp_col_q.push_back(col[`COL_BITS-1:0]);
                end
                default: rc = 0;
            endcase
            if (rc != 1) begin
                $display("stimulus file has a bad line with tag %c", tag);
                fail_count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic send_beat(input in_op_e op, input logic [31:0] data);
        int wait_cnt;
        wait_cnt   = 0;
        i_in_valid = 1'b1;
        i_in_op    = op;
        i_in_data  = data;
        while (!o_in_ready && wait_cnt < ACCEPT_TIMEOUT) begin
            @(negedge s_clk);
            wait_cnt++;
        end
        stall_cycles += wait_cnt;
        if (!o_in_ready) begin
            $display("timeout: input beat %0d was never accepted", beat_idx);
            fail_count++;
            timed_out  = 1'b1;
            i_in_valid = 1'b0;
        end else begin
            @(negedge s_clk);
            i_in_valid = 1'b0;
            if (op == OP_SPIKE) begin
                spike_beats++;
                // row complete, input must close while the columns run
                if (spike_beats % `ERS_PE_SIZE == 0 && o_in_ready) begin
                    $display("input ready stayed high after a row completed at %0t", $time);
                    fail_count++;
                end
            end
        end
    endtask

    task automatic check_output();
        spike_vec_t           e_spikes;
        vmem_t                e_vmem;
        logic [`COL_BITS-1:0] e_col;
        if (exp_spikes_q.size() == 0) begin
            $display("an output column arrived with none left to expect at %0t", $time);
            fail_count++;
            return;
        end
        e_spikes = exp_spikes_q.pop_front();
        e_vmem   = exp_vmem_q.pop_front();
        e_col    = exp_col_q.pop_front();
        if (o_out_col !== e_col) begin
            $display("Mismatch at %0t: column %0d, expected %0d", $time, o_out_col, e_col);
            mismatch_count++;
        end
        if (o_out_spikes !== e_spikes) begin
            $display("Mismatch at %0t: column %0d spikes %h, expected %h",
                     $time, e_col, o_out_spikes, e_spikes);
            mismatch_count++;
        end
        if (o_out_vmem !== e_vmem) begin
            $display("Mismatch at %0t: column %0d membrane %0d, expected %0d",
                     $time, e_col, o_out_vmem, e_vmem);
            mismatch_count++;
        end
        if (o_out_last !== (e_col == `COL_BITS'(`IMG_WIDTH - 1))) begin
            $display("Mismatch at %0t: column %0d last flag %b", $time, e_col, o_out_last);
            mismatch_count++;
        end
        rx_count++;
    endtask

    // ready and the transfer decision live in one block
    always @(negedge s_clk) begin
        lfsr        = lfsr_step(lfsr);
        i_out_ready = lfsr[0];
        if (held_valid) begin
            if (!o_out_valid || o_out_spikes !== held_spikes || o_out_vmem !== held_vmem
                || o_out_col !== held_col || o_out_last !== held_last) begin
                $display("Mismatch at %0t: stalled output column %0d changed", $time, held_col);
                mismatch_count++;
            end
        end
        if (o_out_valid && i_out_ready) begin
            check_output();
            held_valid = 1'b0;
        end else begin
            held_valid  = o_out_valid;
            held_spikes = o_out_spikes;
            held_vmem   = o_out_vmem;
            held_col    = o_out_col;
            held_last   = o_out_last;
        end
    end

    initial begin
        s_rst       = 1'b1;
        i_in_valid  = 1'b0;
        i_in_op     = OP_WEIGHT;
        i_in_data   = '0;
        i_threshold = '0;
        read_stimulus();
        exp_total   = exp_spikes_q.size();
        i_threshold = threshold_cfg;
        repeat (4) @(negedge s_clk);
        s_rst = 1'b0;
        @(negedge s_clk);
        if (!o_in_ready || o_out_valid) begin
            $display("stream handshake in the wrong state after reset");
            fail_count++;
        end
        beat_idx = 0;
        while (beat_idx < beat_op_q.size() && !timed_out) begin
            send_beat(beat_op_q[beat_idx], beat_data_q[beat_idx]);
            beat_idx++;
        end
        drain_cnt = 0;
        while (!timed_out && rx_count < exp_total && drain_cnt < DRAIN_TIMEOUT) begin
            @(negedge s_clk);
            drain_cnt++;
        end
        if (!timed_out && rx_count < exp_total) begin
            $display("timeout: only %0d of %0d columns arrived", rx_count, exp_total);
            fail_count++;
        end
        // quiet window, stray columns get flagged by the monitor
        repeat (20) @(negedge s_clk);
        if (stall_cycles == 0) begin
            $display("no input beat ever had to wait for ready");
            fail_count++;
        end
        $display("checks done: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/snn_conv_pkg.sv
rtl/eyeriss_pe.sv
rtl/if_neuron.sv
rtl/conv_row_ctrl.sv
rtl/spike_conv_top.sv
verif/spike_conv_tb.sv

// ==== verif/spike_conv_stimulus.txt ====
# T threshold hex | W kernel row hex, byte k is weight k | S spike row hex, nibble p is pixel p
# E expected spikes hex, membrane hex (14 bit two's complement), column
T 0004
W 000000
W 000003
W 000000
S FFFFFFFF
S 81C03A5F
S 12345678
E 0 0000 0
E E 0000 1
E 4 0002 2
E 8 0002 3
E 2 0002 4
E 0 0000 5
E 8 0002 6
E 0 0003 7
W 00FF0201
W 00000300
W 000200F8
S FFFFFFFF
S C3C3C3C3
S 0000F000
E 3 0002 0
E E 0002 1
E F 0006 2
E E 0002 3
E 0 3FEE 4
E E 0002 5
E 7 0002 6
E E 0006 7
S 0000000F
S 00F00000
S F0000000
E A 0000 0
E 8 0000 1
E 0 0000 2
E 0 0000 3
E 0 0000 4
E E 0000 5
E A 0000 6
E 0 0000 7
